/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
+incdir+verilog
verilog/id_pkg.sv
verilog/id_ctrl_if.sv
verilog/id_decoder.sv
verilog/id_register_file.sv
verilog/id_operand_mux.sv
verilog/id_wb_fsm.sv
verilog/id_stage.sv
verification/tb_clock_gen.sv
verification/tb_id_stage.sv

/* verification/tb_clock_gen.sv */
// Testbench clock and reset source, 8 ns period with reset held low for two cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* verification/tb_id_stage.sv */
// Random instruction testbench for the decode stage, checking against a shadow register model
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage;

  localparam int NUM_INSTR   = 400;
  // Idle cycle, up to two back-pressure cycles and the final cycle
  localparam int MAX_CYCLES  = 4;
  localparam int CYCLE_LIMIT = 4 * (NUM_INSTR * MAX_CYCLES + 16);

  localparam int K_OP     = 0;
  localparam int K_OP_IMM = 1;
  localparam int K_LUI    = 2;
  localparam int K_AUIPC  = 3;
  localparam int K_LOAD   = 4;
  localparam int K_STORE  = 5;
  localparam int K_BRANCH = 6;
  localparam int K_JAL    = 7;
  localparam int K_JALR   = 8;
  localparam int K_ILL    = 9;

  logic                clk;
  logic                rst_n;
  logic                instr_valid;
  logic [`ID_XLEN-1:0] instr;
  logic [`ID_XLEN-1:0] pc;
  logic                branch_decision;
  logic                ex_ready;
  logic [`ID_XLEN-1:0] wdata_ex;
  logic [`ID_XLEN-1:0] wdata_lsu;
  id_pkg::alu_op_e     alu_operator;
  logic [`ID_XLEN-1:0] operand_a;
  logic [`ID_XLEN-1:0] operand_b;
  logic                data_req;
  logic                data_we;
  logic [1:0]          data_type;
  logic [`ID_XLEN-1:0] data_wdata;
  logic                illegal_insn;
  logic                id_ready;
  logic                pc_set;

  // Reference register state, index zero is never written
  logic [`ID_XLEN-1:0] shadow [`ID_NUM_REGS];
  logic [31:0]         lcg_state;
  int                  cycle_cnt;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  id_stage UUT (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .instr_valid_i      (instr_valid),
    .instr_rdata_i      (instr),
    .pc_id_i            (pc),
    .branch_decision_i  (branch_decision),
    .ex_ready_i         (ex_ready),
    .regfile_wdata_ex_i (wdata_ex),
    .regfile_wdata_lsu_i(wdata_lsu),
    .alu_operator_o     (alu_operator),
    .alu_operand_a_o    (operand_a),
    .alu_operand_b_o    (operand_b),
    .data_req_o         (data_req),
    .data_we_o          (data_we),
    .data_type_o        (data_type),
    .data_wdata_o       (data_wdata),
    .illegal_insn_o     (illegal_insn),
    .id_ready_o         (id_ready),
    .pc_set_o           (pc_set)
  );

  //////////////////////////////////////////////////
  // Checking and failure reporting
  //////////////////////////////////////////////////

  task automatic report_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  // Run length limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("** Error at %0t ns: run did not finish within %0d cycles", $time, CYCLE_LIMIT);
      report_failure();
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] imm_i(input logic [31:0] w);
    return 32'($signed(w[31:20]));
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] w);
    return 32'($signed({w[31:25], w[11:7]}));
  endfunction

  function automatic logic [31:0] imm_u(input logic [31:0] w);
    return {w[31:12], 12'h000};
  endfunction

  // ALU operation expected from opcode class, funct3 and funct7
  function automatic logic [3:0] expected_alu_op(input logic [31:0] w, input int kind);
    logic [2:0] f3;
    logic       alt;
    f3  = w[14:12];
    alt = w[30];
    if (kind == K_OP || kind == K_OP_IMM) begin
      case (f3)
        3'd0:    return (kind == K_OP && alt) ? 4'(id_pkg::ALU_SUB) : 4'(id_pkg::ALU_ADD);
        3'd1:    return 4'(id_pkg::ALU_SLL);
        3'd2:    return 4'(id_pkg::ALU_SLT);
        3'd3:    return 4'(id_pkg::ALU_SLTU);
        3'd4:    return 4'(id_pkg::ALU_XOR);
        3'd5:    return alt ? 4'(id_pkg::ALU_SRA) : 4'(id_pkg::ALU_SRL);
        3'd6:    return 4'(id_pkg::ALU_OR);
        default: return 4'(id_pkg::ALU_AND);
      endcase
    end
    if (kind == K_BRANCH) begin
      case (f3)
        3'd0:    return 4'(id_pkg::ALU_EQ);
        3'd1:    return 4'(id_pkg::ALU_NE);
        3'd4:    return 4'(id_pkg::ALU_LT);
        3'd5:    return 4'(id_pkg::ALU_GE);
        3'd6:    return 4'(id_pkg::ALU_LTU);
        default: return 4'(id_pkg::ALU_GEU);
      endcase
    end
    return 4'(id_pkg::ALU_ADD);
  endfunction

  // Random instruction with legal fields for its class
  task automatic build_instr(input int kind, output logic [31:0] word);
    logic [31:0] r;
    logic [2:0]  f3;
    r    = next_random();
    word = next_random();
    f3   = word[14:12];
    // Bias toward x0 as destination
    if (r[27:25] == 3'd0) begin
      word[11:7] = 5'd0;
    end
    case (kind)
      K_OP: begin
        word[6:0]   = 7'(id_pkg::OPCODE_OP);
        word[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[20]) ? 7'h20 : 7'h00;
      end
      K_OP_IMM: begin
        word[6:0] = 7'(id_pkg::OPCODE_OP_IMM);
        if (f3 == 3'd1) begin
          word[31:25] = 7'h00;
        end else if (f3 == 3'd5) begin
          word[31:25] = r[20] ? 7'h20 : 7'h00;
        end
      end
      K_LUI:   word[6:0] = 7'(id_pkg::OPCODE_LUI);
      K_AUIPC: word[6:0] = 7'(id_pkg::OPCODE_AUIPC);
      K_LOAD: begin
        word[6:0] = 7'(id_pkg::OPCODE_LOAD);
        f3 = {r[22], (r[21:20] == 2'b11) ? 2'b10 : r[21:20]};
        if (f3[2]) begin
          f3[1] = 1'b0;
        end
        word[14:12] = f3;
      end
      K_STORE: begin
        word[6:0]   = 7'(id_pkg::OPCODE_STORE);
        word[14:12] = {1'b0, (r[21:20] == 2'b11) ? 2'b10 : r[21:20]};
      end
      K_BRANCH: begin
        word[6:0] = 7'(id_pkg::OPCODE_BRANCH);
        if (f3[2:1] == 2'b01) begin
          word[13] = 1'b0;
        end
      end
      K_JAL: word[6:0] = 7'(id_pkg::OPCODE_JAL);
      K_JALR: begin
        word[6:0]   = 7'(id_pkg::OPCODE_JALR);
        word[14:12] = 3'd0;
      end
      default: word[6:0] = 7'h0b;
    endcase
  endtask

  //////////////////////////////////////////////////
  // One instruction from issue to completion
  //////////////////////////////////////////////////

  task automatic run_instr();
    logic [31:0] word;
    logic [31:0] r;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    int          kind;
    int          stalls;
    logic        is_mem;
    logic        is_jump;
    logic        taken;
    logic        multi;
    logic        done;
    kind = int'(next_random() % 32'd10);
    build_instr(kind, word);
    rs1 = word[19:15];
    rs2 = word[24:20];
    rd  = word[11:7];
    r   = next_random();
    instr_valid     = 1'b1;
    instr           = word;
    pc              = {r[31:2], 2'b00};
    branch_decision = r[0];
    ex_ready        = r[1];
    wdata_ex        = next_random();
    wdata_lsu       = next_random();
    is_mem  = (kind == K_LOAD) || (kind == K_STORE);
    is_jump = (kind == K_JAL) || (kind == K_JALR);
    taken   = (kind == K_BRANCH) && branch_decision;
    multi   = is_mem || is_jump || taken;

    @(negedge clk);
    check_bit("illegal_insn_o", illegal_insn, kind == K_ILL);
    check_bit("data_req_o", data_req, is_mem);
    check_bit("data_we_o", data_we, kind == K_STORE);
    check_bit("id_ready_o", id_ready, !multi);
    check_bit("pc_set_o", pc_set, is_jump || taken);
    if (is_mem) begin
      check_word("data_type_o", 32'(data_type), 32'(word[13:12]));
    end
    if (kind == K_STORE) begin
      check_word("data_wdata_o", data_wdata, shadow[rs2]);
    end
    if (kind != K_ILL) begin
      case (kind)
        K_LUI:                   exp_a = '0;
        K_AUIPC, K_JAL, K_JALR:  exp_a = pc;
        default:                 exp_a = shadow[rs1];
      endcase
      case (kind)
        K_OP, K_BRANCH:          exp_b = shadow[rs2];
        K_STORE:                 exp_b = imm_s(word);
        K_LUI, K_AUIPC:          exp_b = imm_u(word);
        K_JAL, K_JALR:           exp_b = 32'(`ID_PC_INCR);
        default:                 exp_b = imm_i(word);
      endcase
      check_word("alu_operand_a_o", operand_a, exp_a);
      check_word("alu_operand_b_o", operand_b, exp_b);
      check_word("alu_operator_o", 32'(alu_operator), 32'(expected_alu_op(word, kind)));
    end

    @(posedge clk);
    if (!multi && kind <= K_AUIPC && rd != 5'd0) begin
      shadow[rd] = wdata_ex;
    end
    #1;
    if (multi) begin
      r      = next_random();
      stalls = int'(r % 32'd3);
      done   = 1'b0;
      while (!done) begin
        ex_ready        = (stalls == 0);
        branch_decision = r[stalls];
        wdata_ex        = next_random();
        wdata_lsu       = next_random();
        @(negedge clk);
        check_bit("id_ready_o", id_ready, ex_ready);
        check_bit("pc_set_o", pc_set, 1'b0);
        done = id_ready;
        @(posedge clk);
        if (done && rd != 5'd0) begin
          if (kind == K_LOAD) begin
            shadow[rd] = wdata_lsu;
          end else if (is_jump) begin
            shadow[rd] = wdata_ex;
          end
        end
        #1;
        stalls = stalls - 1;
      end
    end
  endtask

  initial begin
    logic [31:0] idle_word;
    instr_valid     = 1'b0;
    instr           = '0;
    pc              = '0;
    branch_decision = 1'b0;
    ex_ready        = 1'b0;
    wdata_ex        = '0;
    wdata_lsu       = '0;
    cycle_cnt       = 0;
    lcg_state       = 32'hca0040a9;
    for (int i = 0; i < `ID_NUM_REGS; i++) begin
      shadow[i] = '0;
    end

    @(posedge rst_n);
    @(posedge clk);
    #1;

    // Every class held invalid must not request, stall, redirect or write
    for (int k = K_OP; k < K_ILL; k++) begin
      build_instr(k, idle_word);
      instr           = idle_word;
      branch_decision = 1'b1;
      ex_ready        = 1'b1;
      wdata_ex        = next_random();
      wdata_lsu       = next_random();
      @(negedge clk);
      check_bit("data_req_o", data_req, 1'b0);
      check_bit("illegal_insn_o", illegal_insn, 1'b0);
      check_bit("id_ready_o", id_ready, 1'b1);
      check_bit("pc_set_o", pc_set, 1'b0);
      @(posedge clk);
      #1;
    end

    repeat (NUM_INSTR) begin
      run_instr();
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* verilog/id_ctrl_if.sv */
// Decoded control bundle from the decoder to the operand mux and write-back FSM
`timescale 1ns/1ps

interface id_ctrl_if;

  // ALU and operand control
  id_pkg::alu_op_e   alu_operator;
  id_pkg::op_a_sel_e op_a_sel;
  id_pkg::op_b_sel_e op_b_sel;
  id_pkg::imm_sel_e  imm_sel;

  // Qualified enables
  logic              regfile_we;
  logic              data_req;
  logic              data_we;
  logic [1:0]        data_type;
  logic              branch_in_id;
  logic              jump_in_id;

  modport decoder (
    output alu_operator, op_a_sel, op_b_sel, imm_sel,
    output regfile_we, data_req, data_we, data_type,
    output branch_in_id, jump_in_id
  );

  modport operand (
    input alu_operator, op_a_sel, op_b_sel, imm_sel
  );

  modport wb (
    input regfile_we, data_req, branch_in_id, jump_in_id
  );

endinterface

/* verilog/id_decoder.sv */
// Instruction decoder that turns one RV32I word into qualified control for the decode stage
`timescale 1ns/1ps
`include "id_settings.svh"

module id_decoder (
  input  logic                      instr_valid_i,
  input  logic [`ID_XLEN-1:0]       instr_rdata_i,
  output logic [`ID_REG_ADDR_W-1:0] raddr_a_o,
  output logic [`ID_REG_ADDR_W-1:0] raddr_b_o,
  output logic                      illegal_insn_o,
  id_ctrl_if.decoder                ctrl_o
);

  id_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  // Raw decode before qualification
  logic            illegal;
  logic            regfile_we;
  logic            data_req;
  logic            data_we;
  logic            branch_in_id;
  logic            jump_in_id;
  logic            qualify;

  assign opcode    = id_pkg::opcode_e'(instr_rdata_i[`ID_OPCODE_FIELD]);
  assign funct3    = instr_rdata_i[`ID_FUNCT3_FIELD];
  assign funct7    = instr_rdata_i[`ID_FUNCT7_FIELD];
  assign raddr_a_o = instr_rdata_i[`ID_RS1_FIELD];
  assign raddr_b_o = instr_rdata_i[`ID_RS2_FIELD];

  always_comb begin
    ctrl_o.alu_operator = id_pkg::ALU_ADD;
    ctrl_o.op_a_sel     = id_pkg::OP_A_REG;
    ctrl_o.op_b_sel     = id_pkg::OP_B_REG;
    ctrl_o.imm_sel      = id_pkg::IMM_I;
    ctrl_o.data_type    = 2'b00;
    illegal             = 1'b0;
    regfile_we          = 1'b0;
    data_req            = 1'b0;
    data_we             = 1'b0;
    branch_in_id        = 1'b0;
    jump_in_id          = 1'b0;

    case (opcode)
      id_pkg::OPCODE_OP: begin
        regfile_we = 1'b1;
        // Only bit 5 of funct7 may be set, and only for SUB and SRA
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_o.alu_operator = id_pkg::ALU_ADD;
          {7'h20, 3'b000}: ctrl_o.alu_operator = id_pkg::ALU_SUB;
          {7'h00, 3'b001}: ctrl_o.alu_operator = id_pkg::ALU_SLL;
          {7'h00, 3'b010}: ctrl_o.alu_operator = id_pkg::ALU_SLT;
          {7'h00, 3'b011}: ctrl_o.alu_operator = id_pkg::ALU_SLTU;
          {7'h00, 3'b100}: ctrl_o.alu_operator = id_pkg::ALU_XOR;
          {7'h00, 3'b101}: ctrl_o.alu_operator = id_pkg::ALU_SRL;
          {7'h20, 3'b101}: ctrl_o.alu_operator = id_pkg::ALU_SRA;
          {7'h00, 3'b110}: ctrl_o.alu_operator = id_pkg::ALU_OR;
          {7'h00, 3'b111}: ctrl_o.alu_operator = id_pkg::ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end

      id_pkg::OPCODE_OP_IMM: begin
        regfile_we      = 1'b1;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        unique case (funct3)
          3'b000: ctrl_o.alu_operator = id_pkg::ALU_ADD;
          3'b010: ctrl_o.alu_operator = id_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_operator = id_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_operator = id_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_operator = id_pkg::ALU_OR;
          3'b111: ctrl_o.alu_operator = id_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_operator = id_pkg::ALU_SLL;
            illegal             = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, arithmetic when funct7 is 0x20
            ctrl_o.alu_operator = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            illegal             = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      id_pkg::OPCODE_LUI: begin
        regfile_we      = 1'b1;
        ctrl_o.op_a_sel = id_pkg::OP_A_ZERO;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_U;
      end

      id_pkg::OPCODE_AUIPC: begin
        regfile_we      = 1'b1;
        ctrl_o.op_a_sel = id_pkg::OP_A_PC;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_U;
      end

      id_pkg::OPCODE_LOAD: begin
        regfile_we       = 1'b1;
        data_req         = 1'b1;
        ctrl_o.op_b_sel  = id_pkg::OP_B_IMM;
        // Byte, half or word with signed and unsigned variants
        ctrl_o.data_type = funct3[1:0];
        illegal          = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end

      id_pkg::OPCODE_STORE: begin
        data_req         = 1'b1;
        data_we          = 1'b1;
        ctrl_o.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel   = id_pkg::IMM_S;
        ctrl_o.data_type = funct3[1:0];
        illegal          = funct3[2] || (funct3[1:0] == 2'b11);
      end

      id_pkg::OPCODE_BRANCH: begin
        branch_in_id   = 1'b1;
        ctrl_o.imm_sel = id_pkg::IMM_B;
        unique case (funct3)
          3'b000:  ctrl_o.alu_operator = id_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_operator = id_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_operator = id_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_operator = id_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_operator = id_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_operator = id_pkg::ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      id_pkg::OPCODE_JAL, id_pkg::OPCODE_JALR: begin
        // Link value is PC plus increment, the target comes from execute
        regfile_we      = 1'b1;
        jump_in_id      = 1'b1;
        ctrl_o.op_a_sel = id_pkg::OP_A_PC;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_PCINCR;
        illegal         = (opcode == id_pkg::OPCODE_JALR) && (funct3 != 3'b000);
      end

      default: illegal = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // Qualification with instruction valid
  //////////////////////////////////////////////////

  assign qualify             = instr_valid_i & ~illegal;
  assign illegal_insn_o      = instr_valid_i & illegal;
  assign ctrl_o.regfile_we   = regfile_we & qualify;
  assign ctrl_o.data_req     = data_req & qualify;
  assign ctrl_o.data_we      = data_we & qualify;
  assign ctrl_o.branch_in_id = branch_in_id & qualify;
  assign ctrl_o.jump_in_id   = jump_in_id & qualify;

endmodule

/* verilog/id_operand_mux.sv */
// Immediate generation and ALU operand selection for the decode stage
`timescale 1ns/1ps
`include "id_settings.svh"

module id_operand_mux (
  input  logic [`ID_XLEN-1:0] instr_rdata_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  input  logic [`ID_XLEN-1:0] rdata_a_i,
  input  logic [`ID_XLEN-1:0] rdata_b_i,
  id_ctrl_if.operand          ctrl_i,
  output id_pkg::alu_op_e     alu_operator_o,
  output logic [`ID_XLEN-1:0] alu_operand_a_o,
  output logic [`ID_XLEN-1:0] alu_operand_b_o
);

  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_b_type;
  logic [`ID_XLEN-1:0] imm_u_type;
  logic [`ID_XLEN-1:0] imm_j_type;
  logic [`ID_XLEN-1:0] imm_pcincr;
  logic [`ID_XLEN-1:0] imm;

  // Sign extension from instruction bit 31
  assign imm_i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b_type = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                       instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_type = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                       instr_rdata_i[30:21], 1'b0};
  assign imm_pcincr = `ID_XLEN'(`ID_PC_INCR);

  always_comb begin
    unique case (ctrl_i.imm_sel)
      id_pkg::IMM_S:      imm = imm_s_type;
      id_pkg::IMM_B:      imm = imm_b_type;
      id_pkg::IMM_U:      imm = imm_u_type;
      id_pkg::IMM_J:      imm = imm_j_type;
      id_pkg::IMM_PCINCR: imm = imm_pcincr;
      default:            imm = imm_i_type;
    endcase
  end

  // Operand A
  always_comb begin
    unique case (ctrl_i.op_a_sel)
      id_pkg::OP_A_REG: alu_operand_a_o = rdata_a_i;
      id_pkg::OP_A_PC:  alu_operand_a_o = pc_id_i;
      default:          alu_operand_a_o = '0;
    endcase
  end

  // Operand B
  assign alu_operand_b_o = (ctrl_i.op_b_sel == id_pkg::OP_B_IMM) ? imm : rdata_b_i;
  assign alu_operator_o  = ctrl_i.alu_operator;

endmodule

/* verilog/id_pkg.sv */
// Type definitions shared by the decode stage modules, referenced by scoped name
package id_pkg;

  // RV32I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU operations including branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_PCINCR
  } imm_sel_e;

  // Write-back sequencing
  typedef enum logic {
    IDLE,
    WAIT_MULTICYCLE
  } wb_fsm_e;

  typedef enum logic {
    WB_SRC_EX,
    WB_SRC_LSU
  } wb_src_e;

endpackage

/* verilog/id_register_file.sv */
// Decode stage register file with two combinational reads and one clocked write
`timescale 1ns/1ps
`include "id_settings.svh"

module id_register_file (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_b_i,
  input  logic [`ID_REG_ADDR_W-1:0] waddr_i,
  input  logic [`ID_XLEN-1:0]       wdata_i,
  input  logic                      we_i,
  output logic [`ID_XLEN-1:0]       rdata_a_o,
  output logic [`ID_XLEN-1:0]       rdata_b_o
);

  // Storage for x1 to x31 only
  logic [`ID_XLEN-1:0] mem_q [1:`ID_NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `ID_NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is hard-wired to zero
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if (raddr_a_i != '0) begin
      rdata_a_o = mem_q[raddr_a_i];
    end
    if (raddr_b_i != '0) begin
      rdata_b_o = mem_q[raddr_b_i];
    end
  end

endmodule

/* verilog/id_settings.svh */
// Width and instruction field macros included by the decode stage RTL and testbench
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Data path and instruction width
`define ID_XLEN 32

// Architectural register file
`define ID_NUM_REGS   32
`define ID_REG_ADDR_W 5

// Register index fields
`define ID_RS1_FIELD 19:15
`define ID_RS2_FIELD 24:20
`define ID_RD_FIELD  11:7

// Opcode and function fields
`define ID_OPCODE_FIELD 6:0
`define ID_FUNCT3_FIELD 14:12
`define ID_FUNCT7_FIELD 31:25

// Link value and sequential PC step
`define ID_PC_INCR 4

`endif

/* verilog/id_stage.sv */
// RV32I instruction decode stage top level with plain ports toward fetch, execute and LSU
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  input  logic [`ID_XLEN-1:0] instr_rdata_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  input  logic                branch_decision_i,
  input  logic                ex_ready_i,
  input  logic [`ID_XLEN-1:0] regfile_wdata_ex_i,
  input  logic [`ID_XLEN-1:0] regfile_wdata_lsu_i,
  output id_pkg::alu_op_e     alu_operator_o,
  output logic [`ID_XLEN-1:0] alu_operand_a_o,
  output logic [`ID_XLEN-1:0] alu_operand_b_o,
  output logic                data_req_o,
  output logic                data_we_o,
  output logic [1:0]          data_type_o,
  output logic [`ID_XLEN-1:0] data_wdata_o,
  output logic                illegal_insn_o,
  output logic                id_ready_o,
  output logic                pc_set_o
);

  logic [`ID_REG_ADDR_W-1:0] raddr_a;
  logic [`ID_REG_ADDR_W-1:0] raddr_b;
  logic [`ID_REG_ADDR_W-1:0] waddr;
  logic [`ID_XLEN-1:0]       wdata;
  logic                      we;
  logic [`ID_XLEN-1:0]       rdata_a;
  logic [`ID_XLEN-1:0]       rdata_b;

  id_ctrl_if ctrl_if ();

  id_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_rdata_i (instr_rdata_i),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .illegal_insn_o(illegal_insn_o),
    .ctrl_o        (ctrl_if.decoder)
  );

  id_register_file u_register_file (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a),
    .raddr_b_i(raddr_b),
    .waddr_i  (waddr),
    .wdata_i  (wdata),
    .we_i     (we),
    .rdata_a_o(rdata_a),
    .rdata_b_o(rdata_b)
  );

  id_operand_mux u_operand_mux (
    .instr_rdata_i  (instr_rdata_i),
    .pc_id_i        (pc_id_i),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .ctrl_i         (ctrl_if.operand),
    .alu_operator_o (alu_operator_o),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  id_wb_fsm u_wb_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .ctrl_i             (ctrl_if.wb),
    .branch_decision_i  (branch_decision_i),
    .ex_ready_i         (ex_ready_i),
    .regfile_wdata_ex_i (regfile_wdata_ex_i),
    .regfile_wdata_lsu_i(regfile_wdata_lsu_i),
    .rd_i               (instr_rdata_i[`ID_RD_FIELD]),
    .we_o               (we),
    .waddr_o            (waddr),
    .wdata_o            (wdata),
    .id_ready_o         (id_ready_o),
    .pc_set_o           (pc_set_o)
  );

  // LSU request fields
  assign data_req_o   = ctrl_if.data_req;
  assign data_we_o    = ctrl_if.data_we;
  assign data_type_o  = ctrl_if.data_type;
  assign data_wdata_o = rdata_b;

endmodule

/* verilog/id_wb_fsm.sv */
// Write-back FSM that stalls multicycle instructions and drives the register file write port
`timescale 1ns/1ps
`include "id_settings.svh"

module id_wb_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  id_ctrl_if.wb                     ctrl_i,
  input  logic                      branch_decision_i,
  input  logic                      ex_ready_i,
  input  logic [`ID_XLEN-1:0]       regfile_wdata_ex_i,
  input  logic [`ID_XLEN-1:0]       regfile_wdata_lsu_i,
  input  logic [`ID_REG_ADDR_W-1:0] rd_i,
  output logic                      we_o,
  output logic [`ID_REG_ADDR_W-1:0] waddr_o,
  output logic [`ID_XLEN-1:0]       wdata_o,
  output logic                      id_ready_o,
  output logic                      pc_set_o
);

  id_pkg::wb_fsm_e state_q;
  id_pkg::wb_fsm_e state_n;
  id_pkg::wb_src_e wb_src;
  logic            stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= id_pkg::IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////////////////////////
  // Next state and stall
  //////////////////////////////////////////////////

  always_comb begin
    state_n  = state_q;
    we_o     = ctrl_i.regfile_we;
    wb_src   = id_pkg::WB_SRC_EX;
    stall    = 1'b0;
    pc_set_o = 1'b0;

    unique case (state_q)
      id_pkg::IDLE: begin
        if (ctrl_i.data_req) begin
          // Loads and stores wait for the LSU
          we_o    = 1'b0;
          stall   = 1'b1;
          state_n = id_pkg::WAIT_MULTICYCLE;
        end else if (ctrl_i.branch_in_id) begin
          // Not-taken branch retires here
          if (branch_decision_i) begin
            stall    = 1'b1;
            pc_set_o = 1'b1;
            state_n  = id_pkg::WAIT_MULTICYCLE;
          end
        end else if (ctrl_i.jump_in_id) begin
          we_o     = 1'b0;
          stall    = 1'b1;
          pc_set_o = 1'b1;
          state_n  = id_pkg::WAIT_MULTICYCLE;
        end
      end

      default: begin
        if (ex_ready_i) begin
          state_n = id_pkg::IDLE;
          wb_src  = ctrl_i.data_req ? id_pkg::WB_SRC_LSU : id_pkg::WB_SRC_EX;
        end else begin
          we_o  = 1'b0;
          stall = 1'b1;
        end
      end
    endcase
  end

  assign waddr_o    = rd_i;
  assign wdata_o    = (wb_src == id_pkg::WB_SRC_LSU) ? regfile_wdata_lsu_i : regfile_wdata_ex_i;
  assign id_ready_o = ~stall;

endmodule
